// File: build.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/stage_ctrl.sv
rtl/decode_stage.sv
tests/decode_stage_assertions.sv
tests/decode_stage_tb.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' build.f) rtl/decode_consts.svh

.PHONY: all run clean

all: run

obj_dir/Vdecode_stage_tb: build.f $(SOURCES)
	verilator --binary --timing --assert -f build.f --top-module decode_stage_tb \
		-o Vdecode_stage_tb

run: obj_dir/Vdecode_stage_tb
	./obj_dir/Vdecode_stage_tb | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/decode_stage_tb.sv
`default_nettype none

`include "decode_consts.svh"

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import decode_pkg::*;

    typedef struct packed {
        logic      fs_valid;
        fs_to_ds_t fetch;
        fwd_bus_t  fwd;
        rf_write_t wb;
        logic      es_allowin;
        logic      exp_valid;
        logic      exp_allowin;
        logic      chk_bus;
        logic      chk_ine;
        ds_to_es_t exp_bus;
        br_bus_t   exp_br;
    } step_t;

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds_bus;
    logic      ds_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    logic      es_allowin;
    br_bus_t   br_bus;
    fwd_bus_t  fwd_bus;
    rf_write_t ws_to_rf_bus;

    step_t               steps[$];
    step_t               cs;
    logic [`DS_XLEN-1:0] rf_model [`DS_NUM_REGS];
    logic [31:0]         lcg_state = 32'h1066452f;
    int                  cycle_count = 0;
    int                  cycle_limit = 0;

    bind decode_stage decode_stage_assertions u_checks (
        .clk(clk), .reset(reset), .es_allowin(es_allowin),
        .ds_to_es_valid(ds_to_es_valid), .ds_to_es_bus(ds_to_es_bus), .br_bus(br_bus)
    );

    decode_stage dut (
        .clk(clk), .reset(reset),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus), .ds_allowin(ds_allowin),
        .ds_to_es_valid(ds_to_es_valid), .ds_to_es_bus(ds_to_es_bus), .es_allowin(es_allowin),
        .br_bus(br_bus), .fwd_bus(fwd_bus), .ws_to_rf_bus(ws_to_rf_bus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic inst_word_t r3_word(logic [16:0] op, reg_addr_t rk, reg_addr_t rj,
                                           reg_addr_t rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic inst_word_t i12_word(logic [9:0] op, logic [11:0] imm, reg_addr_t rj,
                                            reg_addr_t rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic inst_word_t i16_word(logic [5:0] op, logic [15:0] offs, reg_addr_t rj,
                                            reg_addr_t rd);
        return {op, offs, rj, rd};
    endfunction

    // b and bl keep the high offset bits in the register slots
    function automatic inst_word_t b26_word(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic ds_to_es_t expect_alu(logic [31:0] pc, int op_bit, logic imm_src,
                                             reg_addr_t dest, logic [31:0] imm,
                                             logic [31:0] rjv, logic [31:0] rkv);
        ds_to_es_t b;
        b = '0;
        b.pc = pc;
        b.alu_op[op_bit] = 1'b1;
        b.src2_is_imm = imm_src;
        b.gr_we = 1'b1;
        b.dest = dest;
        b.imm = imm;
        b.rj_value = rjv;
        b.rkd_value = rkv;
        return b;
    endfunction

    task automatic prepare_step(input logic drive, input inst_word_t inst,
                                input logic [31:0] pc, input logic check,
                                input ds_to_es_t exp);
        cs = '0;
        cs.es_allowin = 1'b1;
        cs.exp_allowin = 1'b1;
        cs.fs_valid = drive;
        cs.fetch.pc = pc;
        cs.fetch.inst = inst;
        cs.exp_valid = check;
        cs.chk_bus = check;
        cs.exp_bus = exp;
    endtask

    // the model tracks the register file as the write lands at the edge
    task automatic push_step();
        steps.push_back(cs);
        if (cs.wb.we && (cs.wb.waddr != '0)) begin
            rf_model[cs.wb.waddr] = cs.wb.wdata;
        end
    endtask

    task automatic write_reg(input int r);
        prepare_step(1'b0, '0, '0, 1'b0, '0);
        cs.wb = '{we: 1'b1, waddr: reg_addr_t'(r), wdata: lcg_next()};
        push_step();
    endtask

    task automatic run_branch(input inst_word_t inst, input logic [31:0] pc,
                              input logic taken, input logic [31:0] target);
        prepare_step(1'b1, inst, pc, 1'b0, '0);
        push_step();
        // filler add.w r18, r1, r2 right behind the branch
        prepare_step(1'b1, r3_word(17'h20, 5'd2, 5'd1, 5'd18), pc + 32'd4, 1'b0, '0);
        cs.exp_valid = 1'b1;
        cs.exp_br = '{taken: taken, target: target};
        push_step();
        if (taken) begin
            prepare_step(1'b0, '0, '0, 1'b0, '0);
        end else begin
            prepare_step(1'b0, '0, '0, 1'b1,
                         expect_alu(pc + 32'd4, 0, 1'b0, 5'd18, '0, rf_model[1], rf_model[2]));
        end
        push_step();
    endtask

    task automatic build_table();
        logic [31:0] pc;
        logic [31:0] e_data;
        logic [31:0] m_data;
        logic [31:0] w_data;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] target;
        logic [15:0] offs16;
        logic [25:0] offs26;
        logic        cond;
        inst_word_t  ld_inst;
        inst_word_t  sub_inst;
        ds_to_es_t   exp;
        int          kk;
        pc = 32'h1c00_0000;
        rf_model[0] = '0;
        // r0 gets a write too, which must not stick
        for (int r = 0; r <= 6; r++) begin
            write_reg(r);
        end

        // register file reads, r0, and immediate forms
        prepare_step(1'b1, r3_word(17'h20, 5'd2, 5'd1, 5'd7), pc, 1'b0, '0);
        push_step();
        prepare_step(1'b1, r3_word(17'h20, 5'd3, 5'd0, 5'd8), pc + 32'd4, 1'b1,
                     expect_alu(pc, 0, 1'b0, 5'd7, '0, rf_model[1], rf_model[2]));
        push_step();
        prepare_step(1'b1, i12_word(10'h00a, 12'h800, 5'd1, 5'd9), pc + 32'd8, 1'b1,
                     expect_alu(pc + 32'd4, 0, 1'b0, 5'd8, '0, '0, rf_model[3]));
        push_step();
        prepare_step(1'b1, i12_word(10'h00e, 12'h9e0, 5'd2, 5'd10), pc + 32'd12, 1'b1,
                     expect_alu(pc + 32'd8, 0, 1'b1, 5'd9, 32'hfffff800, rf_model[1], '0));
        push_step();
        prepare_step(1'b0, '0, '0, 1'b1,
                     expect_alu(pc + 32'd12, 6, 1'b1, 5'd10, 32'h9e0, rf_model[2], '0));
        push_step();

        // execute beats memory beats write-back
        pc = 32'h1c00_0100;
        prepare_step(1'b1, r3_word(17'h20, 5'd4, 5'd3, 5'd11), pc, 1'b0, '0);
        push_step();
        e_data = lcg_next();
        m_data = lcg_next();
        w_data = lcg_next();
        prepare_step(1'b1, r3_word(17'h20, 5'd5, 5'd3, 5'd12), pc + 32'd4, 1'b1,
                     expect_alu(pc, 0, 1'b0, 5'd11, '0, rf_model[3], e_data));
        cs.fwd = '{exe_waddr: 5'd4, exe_is_load: 1'b0, exe_wdata: e_data,
                   mem_waddr: 5'd4, mem_wdata: m_data};
        cs.wb = '{we: 1'b1, waddr: 5'd4, wdata: w_data};
        push_step();
        m_data = lcg_next();
        w_data = lcg_next();
        prepare_step(1'b0, '0, '0, 1'b1,
                     expect_alu(pc + 32'd4, 0, 1'b0, 5'd12, '0, rf_model[3], m_data));
        cs.fwd = '{exe_waddr: 5'd0, exe_is_load: 1'b0, exe_wdata: '0,
                   mem_waddr: 5'd5, mem_wdata: m_data};
        cs.wb = '{we: 1'b1, waddr: 5'd5, wdata: w_data};
        push_step();

        // load-use stall on r6, then ld.w r14, r1, 0x20 waits in fetch
        pc = 32'h1c00_0200;
        ld_inst = i12_word(10'h0a2, 12'h020, 5'd1, 5'd14);
        prepare_step(1'b1, r3_word(17'h20, 5'd6, 5'd2, 5'd13), pc, 1'b0, '0);
        push_step();
        for (int n = 0; n < 2; n++) begin
            prepare_step(1'b1, ld_inst, pc + 32'd4, 1'b0, '0);
            cs.fwd = '{exe_waddr: 5'd6, exe_is_load: 1'b1, exe_wdata: lcg_next(),
                       mem_waddr: 5'd0, mem_wdata: '0};
            cs.exp_allowin = 1'b0;
            push_step();
        end
        m_data = lcg_next();
        prepare_step(1'b1, ld_inst, pc + 32'd4, 1'b1,
                     expect_alu(pc, 0, 1'b0, 5'd13, '0, rf_model[2], m_data));
        cs.fwd = '{exe_waddr: 5'd0, exe_is_load: 1'b0, exe_wdata: '0,
                   mem_waddr: 5'd6, mem_wdata: m_data};
        push_step();
        exp = expect_alu(pc + 32'd4, 0, 1'b1, 5'd14, 32'h20, rf_model[1], '0);
        exp.load = 1'b1;
        prepare_step(1'b0, '0, '0, 1'b1, exp);
        push_step();

        // back-pressure from execute
        pc = 32'h1c00_0300;
        sub_inst = r3_word(17'h22, 5'd1, 5'd2, 5'd16);
        prepare_step(1'b1, r3_word(17'h20, 5'd2, 5'd1, 5'd15), pc, 1'b0, '0);
        push_step();
        exp = expect_alu(pc, 0, 1'b0, 5'd15, '0, rf_model[1], rf_model[2]);
        for (int n = 0; n < 2; n++) begin
            prepare_step(1'b1, sub_inst, pc + 32'd4, 1'b1, exp);
            cs.es_allowin = 1'b0;
            cs.exp_allowin = 1'b0;
            push_step();
        end
        prepare_step(1'b1, sub_inst, pc + 32'd4, 1'b1, exp);
        push_step();
        prepare_step(1'b0, '0, '0, 1'b1,
                     expect_alu(pc + 32'd4, 1, 1'b0, 5'd16, '0, rf_model[2], rf_model[1]));
        push_step();

        // undefined word, then mul.w which is defined
        pc = 32'h1c00_0400;
        prepare_step(1'b1, inst_word_t'(32'hffff_ffff), pc, 1'b0, '0);
        push_step();
        prepare_step(1'b1, r3_word(17'h38, 5'd2, 5'd1, 5'd17), pc + 32'd4, 1'b0, '0);
        cs.exp_valid = 1'b1;
        cs.chk_ine = 1'b1;
        cs.exp_bus.ine = 1'b1;
        push_step();
        prepare_step(1'b0, '0, '0, 1'b0, '0);
        cs.exp_valid = 1'b1;
        cs.chk_ine = 1'b1;
        push_step();

        // conditional branches; the last two compare r1 with itself
        pc = 32'h1c00_1000;
        for (int k = 0; k < 8; k++) begin
            write_reg(1);
            write_reg(2);
            kk = k % 6;
            a = rf_model[1];
            b = (k >= 6) ? rf_model[1] : rf_model[2];
            case (kk)
                0: cond = (a == b);
                1: cond = (a != b);
                2: cond = ($signed(a) < $signed(b));
                3: cond = ($signed(a) >= $signed(b));
                4: cond = (a < b);
                default: cond = (a >= b);
            endcase
            offs16 = 16'(lcg_next() >> 16);
            target = pc + {{14{offs16[15]}}, offs16, 2'b00};
            run_branch(i16_word(6'h16 + 6'(kk), offs16, 5'd1, (k >= 6) ? 5'd1 : 5'd2),
                       pc, cond, target);
            pc = pc + 32'h40;
        end

        // unconditional b and bl, then jirl off r1
        for (int k = 0; k < 2; k++) begin
            offs26 = 26'(lcg_next());
            target = pc + {{4{offs26[25]}}, offs26, 2'b00};
            run_branch(b26_word(6'h14 + 6'(k), offs26), pc, 1'b1, target);
            pc = pc + 32'h40;
        end
        offs16 = 16'(lcg_next() >> 16);
        target = rf_model[1] + {{14{offs16[15]}}, offs16, 2'b00};
        run_branch(i16_word(6'h13, offs16, 5'd1, 5'd3), pc, 1'b1, target);
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic got,
                               input int idx);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %s step %0d: expected %h got %h",
                                        name, idx, exp, got));
        end
    endtask

    task automatic compare_bundle(input ds_to_es_t exp, input ds_to_es_t got, input int idx);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] ds_to_es_bus step %0d: expected %h got %h",
                                        idx, exp, got));
        end
    endtask

    // target only matters when the branch is taken
    task automatic compare_br(input br_bus_t exp, input br_bus_t got, input int idx);
        if ((got.taken !== exp.taken) || (exp.taken && (got.target !== exp.target))) begin
            stop_with_failure($sformatf("[FAIL] br_bus step %0d: expected %h got %h",
                                        idx, exp, got));
        end
    endtask

    task automatic check_step(input step_t s, input int idx);
        compare_bit("ds_to_es_valid", s.exp_valid, ds_to_es_valid, idx);
        compare_bit("ds_allowin", s.exp_allowin, ds_allowin, idx);
        compare_br(s.exp_br, br_bus, idx);
        if (s.chk_bus) begin
            compare_bundle(s.exp_bus, ds_to_es_bus, idx);
        end
        if (s.chk_ine) begin
            compare_bit("ds_to_es_bus.ine", s.exp_bus.ine, ds_to_es_bus.ine, idx);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit != 0) && (cycle_count > cycle_limit)) begin
            stop_with_failure("the run did not finish within its cycle limit");
        end
    end

    initial begin
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        es_allowin = 1'b1;
        fwd_bus = '0;
        ws_to_rf_bus = '0;
        build_table();
        cycle_limit = steps.size() * 8;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            fs_to_ds_valid = steps[i].fs_valid;
            fs_to_ds_bus = steps[i].fetch;
            fwd_bus = steps[i].fwd;
            ws_to_rf_bus = steps[i].wb;
            es_allowin = steps[i].es_allowin;
            #1;
            check_step(steps[i], i);
            @(negedge clk);
        end
        if (dut.u_checks.failures == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("a protocol assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: tests/decode_stage_assertions.sv
`default_nettype none

module decode_stage_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  es_allowin,
    input logic                  ds_to_es_valid,
    input decode_pkg::ds_to_es_t ds_to_es_bus,
    input decode_pkg::br_bus_t   br_bus
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // a stalled bundle must not move until execute takes it
    bundle_holds: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin
        |=> ds_to_es_valid && $stable(ds_to_es_bus) && $stable(br_bus))
        else begin
            $error("bundle changed while execute was not accepting");
            failures++;
        end

    taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        br_bus.taken |-> ds_to_es_valid)
        else begin
            $error("branch taken without a valid bundle");
            failures++;
        end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

`include "decode_consts.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t fs_to_ds_bus,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::ds_to_es_t ds_to_es_bus,
    input  logic                  es_allowin,
    output decode_pkg::br_bus_t   br_bus,
    input  decode_pkg::fwd_bus_t  fwd_bus,
    input  decode_pkg::rf_write_t ws_to_rf_bus
);
    import decode_pkg::*;

    fs_to_ds_t           cur;
    decode_ctrl_t        ctrl;
    reg_addr_t           rj_addr;
    reg_addr_t           rkd_addr;
    logic                use_rk;
    logic [`DS_XLEN-1:0] rf_rdata1;
    logic [`DS_XLEN-1:0] rf_rdata2;
    logic [`DS_XLEN-1:0] rj_value;
    logic [`DS_XLEN-1:0] rkd_value;
    logic [`DS_XLEN-1:0] br_target;
    logic                load_use;
    logic                br_cond;

    assign rj_addr = cur.inst.r3.rj;
    // stores and conditional branches read rd as second source
    assign rkd_addr = ctrl.src_reg_is_rd ? cur.inst.r3.rd : cur.inst.r3.rk;
    assign use_rk = ~ctrl.src2_is_imm | ctrl.src_reg_is_rd;

    stage_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus),
        .es_allowin(es_allowin), .load_use(load_use),
        .br_cond(br_cond), .br_target(br_target),
        .cur(cur), .ds_allowin(ds_allowin),
        .ds_to_es_valid(ds_to_es_valid), .br_bus(br_bus)
    );

    inst_decoder u_dec (.inst(cur.inst), .ctrl(ctrl));

    regfile u_rf (
        .clk(clk), .raddr1(rj_addr), .raddr2(rkd_addr),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2), .wr(ws_to_rf_bus)
    );

    operand_forward u_fwd (
        .rj(rj_addr), .rkd_addr(rkd_addr), .use_rk(use_rk),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .fwd(fwd_bus), .wb(ws_to_rf_bus),
        .rj_value(rj_value), .rkd_value(rkd_value), .load_use(load_use)
    );

    branch_unit u_br (
        .kind(ctrl.br_kind), .pc(cur.pc), .offs(ctrl.br_offs),
        .rj_value(rj_value), .rkd_value(rkd_value),
        .br_cond(br_cond), .br_target(br_target)
    );

    always_comb begin
        ds_to_es_bus.pc = cur.pc;
        ds_to_es_bus.alu_op = ctrl.alu_op;
        ds_to_es_bus.mul_div = ctrl.mul_div;
        ds_to_es_bus.load = ctrl.load;
        ds_to_es_bus.ld_code = ctrl.ld_code;
        ds_to_es_bus.store = ctrl.store;
        ds_to_es_bus.st_code = ctrl.st_code;
        ds_to_es_bus.src1_is_pc = ctrl.src1_is_pc;
        ds_to_es_bus.src2_is_imm = ctrl.src2_is_imm;
        ds_to_es_bus.gr_we = ctrl.gr_we;
        ds_to_es_bus.dest = ctrl.dest;
        ds_to_es_bus.imm = ctrl.imm;
        ds_to_es_bus.ine = ctrl.ine;
        ds_to_es_bus.rj_value = rj_value;
        ds_to_es_bus.rkd_value = rkd_value;
    end

endmodule

`default_nettype wire

// File: rtl/stage_ctrl.sv
`default_nettype none

`include "decode_consts.svh"

module stage_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t fs_to_ds_bus,
    input  logic                  es_allowin,
    input  logic                  load_use,
    input  logic                  br_cond,
    input  logic [`DS_XLEN-1:0]   br_target,
    output decode_pkg::fs_to_ds_t cur,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::br_bus_t   br_bus
);
    logic ds_valid;
    logic cancel;
    logic drop;
    logic ready_go;

    // the slot right behind a taken branch is thrown away
    assign drop = ds_valid & cancel;
    assign ready_go = drop | ~load_use;
    assign ds_allowin = ~ds_valid | (ready_go & (es_allowin | drop));
    assign ds_to_es_valid = ds_valid & ~cancel & ready_go;

    assign br_bus.taken = br_cond & ds_to_es_valid;
    assign br_bus.target = br_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
            cancel <= 1'b0;
        end else begin
            if (ds_allowin) begin
                ds_valid <= fs_to_ds_valid;
            end
            if (br_bus.taken && es_allowin) begin
                cancel <= 1'b1;
            end else if (drop) begin
                cancel <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            cur <= fs_to_ds_bus;
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`default_nettype none

`include "decode_consts.svh"

module branch_unit (
    input  decode_pkg::br_kind_t kind,
    input  logic [`DS_XLEN-1:0]  pc,
    input  logic [`DS_XLEN-1:0]  offs,
    input  logic [`DS_XLEN-1:0]  rj_value,
    input  logic [`DS_XLEN-1:0]  rkd_value,
    output logic                 br_cond,
    output logic [`DS_XLEN-1:0]  br_target
);
    import decode_pkg::*;

    logic [`DS_XLEN:0] diff;
    logic              eq;
    logic              lt;
    logic              ltu;

    // rj - rkd, carry out set when no borrow
    assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;
    assign eq = diff[`DS_XLEN-1:0] == '0;
    assign ltu = ~diff[`DS_XLEN];
    assign lt = (rj_value[`DS_XLEN-1] & ~rkd_value[`DS_XLEN-1])
              | (~(rj_value[`DS_XLEN-1] ^ rkd_value[`DS_XLEN-1]) & diff[`DS_XLEN-1]);

    always_comb begin
        case (kind)
            BR_B, BR_BL, BR_JIRL: br_cond = 1'b1;
            BR_BEQ:               br_cond = eq;
            BR_BNE:               br_cond = ~eq;
            BR_BLT:               br_cond = lt;
            BR_BGE:               br_cond = ~lt;
            BR_BLTU:              br_cond = ltu;
            BR_BGEU:              br_cond = ~ltu;
            default:              br_cond = 1'b0;
        endcase
    end

    // jirl is register relative, all others pc relative
    assign br_target = ((kind == BR_JIRL) ? rj_value : pc) + offs;

endmodule

`default_nettype wire

// File: rtl/operand_forward.sv
`default_nettype none

`include "decode_consts.svh"

module operand_forward (
    input  decode_pkg::reg_addr_t rj,
    input  decode_pkg::reg_addr_t rkd_addr,
    input  logic                  use_rk,
    input  logic [`DS_XLEN-1:0]   rf_rdata1,
    input  logic [`DS_XLEN-1:0]   rf_rdata2,
    input  decode_pkg::fwd_bus_t  fwd,
    input  decode_pkg::rf_write_t wb,
    output logic [`DS_XLEN-1:0]   rj_value,
    output logic [`DS_XLEN-1:0]   rkd_value,
    output logic                  load_use
);
    import decode_pkg::*;

    // youngest producer wins: execute, then memory, then write-back
    function automatic logic [`DS_XLEN-1:0] bypass(
        input reg_addr_t           addr,
        input logic [`DS_XLEN-1:0] rf_data,
        input fwd_bus_t            f,
        input rf_write_t           w
    );
        if (addr == '0) begin
            return rf_data;
        end else if (addr == f.exe_waddr) begin
            return f.exe_wdata;
        end else if (addr == f.mem_waddr) begin
            return f.mem_wdata;
        end else if (w.we && (addr == w.waddr)) begin
            return w.wdata;
        end
        return rf_data;
    endfunction

    always_comb begin
        rj_value = bypass(rj, rf_rdata1, fwd, wb);
        rkd_value = bypass(rkd_addr, rf_rdata2, fwd, wb);
    end

    // load data is not ready until memory
    assign load_use = fwd.exe_is_load && (fwd.exe_waddr != '0)
                    && ((rj == fwd.exe_waddr) || (use_rk && (rkd_addr == fwd.exe_waddr)));

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`default_nettype none

`include "decode_consts.svh"

module regfile (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output logic [`DS_XLEN-1:0]   rdata1,
    output logic [`DS_XLEN-1:0]   rdata2,
    input  decode_pkg::rf_write_t wr
);
    logic [`DS_XLEN-1:0] regs [`DS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`default_nettype none

`include "decode_consts.svh"

module inst_decoder (
    input  decode_pkg::inst_word_t   inst,
    output decode_pkg::decode_ctrl_t ctrl
);
    import decode_pkg::*;

    logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll, inst_srl, inst_sra, inst_slli, inst_srli, inst_srai;
    logic inst_slti, inst_sltui, inst_addi, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu12i;
    logic is_load, is_store, is_cond_br, link4, known;
    logic need_si12, need_ui12, need_si20;
    logic [`DS_MD_W-1:0]     md_code;
    logic [`DS_ALU_OP_W-1:0] alu_op;
    logic [25:0]             i26;
    ld_code_t ld_code;
    st_code_t st_code;
    br_kind_t kind;

    assign inst_add   = inst.r3.opcode == 17'h00020;
    assign inst_sub   = inst.r3.opcode == 17'h00022;
    assign inst_slt   = inst.r3.opcode == 17'h00024;
    assign inst_sltu  = inst.r3.opcode == 17'h00025;
    assign inst_nor   = inst.r3.opcode == 17'h00028;
    assign inst_and   = inst.r3.opcode == 17'h00029;
    assign inst_or    = inst.r3.opcode == 17'h0002a;
    assign inst_xor   = inst.r3.opcode == 17'h0002b;
    assign inst_sll   = inst.r3.opcode == 17'h0002e;
    assign inst_srl   = inst.r3.opcode == 17'h0002f;
    assign inst_sra   = inst.r3.opcode == 17'h00030;
    // shift amount sits in the rk slot
    assign inst_slli  = inst.r3.opcode == 17'h00081;
    assign inst_srli  = inst.r3.opcode == 17'h00089;
    assign inst_srai  = inst.r3.opcode == 17'h00091;
    assign inst_slti  = inst.i12.opcode == 10'h008;
    assign inst_sltui = inst.i12.opcode == 10'h009;
    assign inst_addi  = inst.i12.opcode == 10'h00a;
    assign inst_andi  = inst.i12.opcode == 10'h00d;
    assign inst_ori   = inst.i12.opcode == 10'h00e;
    assign inst_xori  = inst.i12.opcode == 10'h00f;
    assign inst_lu12i     = inst.i20.opcode == 7'h0a;
    assign inst_pcaddu12i = inst.i20.opcode == 7'h0e;

    always_comb begin
        is_load = 1'b1;
        ld_code = LD_W;
        is_store = 1'b1;
        st_code = ST_W;
        case (inst.i12.opcode)
            10'h0a0: ld_code = LD_B;
            10'h0a1: ld_code = LD_H;
            10'h0a2: ld_code = LD_W;
            10'h0a8: ld_code = LD_BU;
            10'h0a9: ld_code = LD_HU;
            default: is_load = 1'b0;
        endcase
        case (inst.i12.opcode)
            10'h0a4: st_code = ST_B;
            10'h0a5: st_code = ST_H;
            10'h0a6: st_code = ST_W;
            default: is_store = 1'b0;
        endcase
    end

    always_comb begin
        case (inst.i16.opcode)
            6'h13:   kind = BR_JIRL;
            6'h14:   kind = BR_B;
            6'h15:   kind = BR_BL;
            6'h16:   kind = BR_BEQ;
            6'h17:   kind = BR_BNE;
            6'h18:   kind = BR_BLT;
            6'h19:   kind = BR_BGE;
            6'h1a:   kind = BR_BLTU;
            6'h1b:   kind = BR_BGEU;
            default: kind = BR_NONE;
        endcase
    end

    // mul.w mulh.w mulh.wu div.w mod.w div.wu mod.wu
    always_comb begin
        case (inst.r3.opcode)
            17'h00038: md_code = 3'd1;
            17'h00039: md_code = 3'd2;
            17'h0003a: md_code = 3'd3;
            17'h00040: md_code = 3'd4;
            17'h00041: md_code = 3'd5;
            17'h00042: md_code = 3'd6;
            17'h00043: md_code = 3'd7;
            default:   md_code = 3'd0;
        endcase
    end

    assign is_cond_br = kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    assign link4 = (kind == BR_JIRL) || (kind == BR_BL);

    assign alu_op[0]  = inst_add | inst_addi | is_load | is_store | link4;
    assign alu_op[1]  = inst_sub;
    assign alu_op[2]  = inst_slt | inst_slti;
    assign alu_op[3]  = inst_sltu | inst_sltui;
    assign alu_op[4]  = inst_and | inst_andi;
    assign alu_op[5]  = inst_nor;
    assign alu_op[6]  = inst_or | inst_ori;
    assign alu_op[7]  = inst_xor | inst_xori;
    assign alu_op[8]  = inst_sll | inst_slli;
    assign alu_op[9]  = inst_srl | inst_srli;
    assign alu_op[10] = inst_sra | inst_srai;
    assign alu_op[11] = inst_lu12i;
    assign alu_op[12] = inst_pcaddu12i;

    // shifts take the low five bits of the sign-extended field
    assign need_si12 = inst_slti | inst_sltui | inst_addi | is_load | is_store
                     | inst_slli | inst_srli | inst_srai;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i | inst_pcaddu12i;

    assign known = (|alu_op) | (md_code != 3'd0) | (kind != BR_NONE);

    assign i26 = {inst.i16.rj, inst.i16.rd, inst.i16.offs};

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = alu_op;
        ctrl.mul_div = md_code;
        ctrl.load = is_load;
        ctrl.ld_code = ld_code;
        ctrl.store = is_store;
        ctrl.st_code = st_code;
        ctrl.src1_is_pc = link4 | inst_pcaddu12i;
        // b reads no register at all
        ctrl.src2_is_imm = need_si12 | need_ui12 | need_si20 | link4 | (kind == BR_B);
        ctrl.src_reg_is_rd = is_store | is_cond_br;
        ctrl.gr_we = known & ~is_store & ~is_cond_br & (kind != BR_B);
        ctrl.dest = (kind == BR_BL) ? reg_addr_t'(`DS_LINK_REG) : inst.r3.rd;
        ctrl.br_kind = kind;
        ctrl.imm = {32{link4}} & 32'h4
                 | {32{need_si12}} & {{20{inst.i12.imm[11]}}, inst.i12.imm}
                 | {32{need_ui12}} & {20'b0, inst.i12.imm}
                 | {32{need_si20}} & {inst.i20.imm, 12'b0};
        if ((kind == BR_B) || (kind == BR_BL)) begin
            ctrl.br_offs = {{4{i26[25]}}, i26, 2'b0};
        end else begin
            ctrl.br_offs = {{14{inst.i16.offs[15]}}, inst.i16.offs, 2'b0};
        end
        ctrl.ine = ~known;
    end

endmodule

`default_nettype wire

// File: rtl/decode_pkg.sv
`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`DS_REG_AW-1:0] reg_addr_t;

    // three-register layout, also used for shift-by-immediate
    typedef struct packed {
        logic [16:0] opcode;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } i12_fmt_t;

    // branches and jirl; b and bl extend the offset into rj and rd
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } i16_fmt_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm;
        reg_addr_t   rd;
    } i20_fmt_t;

    typedef union packed {
        r3_fmt_t  r3;
        i12_fmt_t i12;
        i16_fmt_t i16;
        i20_fmt_t i20;
    } inst_word_t;

    typedef enum logic [2:0] {
        LD_W  = 3'd0,
        LD_B  = 3'd1,
        LD_BU = 3'd2,
        LD_H  = 3'd3,
        LD_HU = 3'd4
    } ld_code_t;

    typedef enum logic [1:0] {
        ST_W = 2'd0,
        ST_B = 2'd1,
        ST_H = 2'd2
    } st_code_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_B, BR_BL, BR_JIRL,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_kind_t;

    typedef struct packed {
        logic [`DS_ALU_OP_W-1:0] alu_op;
        logic [`DS_MD_W-1:0]     mul_div;
        logic                    load;
        ld_code_t                ld_code;
        logic                    store;
        st_code_t                st_code;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    src_reg_is_rd;
        logic                    gr_we;
        reg_addr_t               dest;
        br_kind_t                br_kind;
        logic [`DS_XLEN-1:0]     imm;
        logic [`DS_XLEN-1:0]     br_offs;
        logic                    ine;
    } decode_ctrl_t;

    typedef struct packed {
        logic [`DS_XLEN-1:0] pc;
        inst_word_t          inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic [`DS_XLEN-1:0]     pc;
        logic [`DS_ALU_OP_W-1:0] alu_op;
        logic [`DS_MD_W-1:0]     mul_div;
        logic                    load;
        ld_code_t                ld_code;
        logic                    store;
        st_code_t                st_code;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    gr_we;
        reg_addr_t               dest;
        logic [`DS_XLEN-1:0]     imm;
        logic                    ine;
        logic [`DS_XLEN-1:0]     rj_value;
        logic [`DS_XLEN-1:0]     rkd_value;
    } ds_to_es_t;

    // zero address in either stage means no pending write
    typedef struct packed {
        reg_addr_t           exe_waddr;
        logic                exe_is_load;
        logic [`DS_XLEN-1:0] exe_wdata;
        reg_addr_t           mem_waddr;
        logic [`DS_XLEN-1:0] mem_wdata;
    } fwd_bus_t;

    typedef struct packed {
        logic                we;
        reg_addr_t           waddr;
        logic [`DS_XLEN-1:0] wdata;
    } rf_write_t;

    typedef struct packed {
        logic                taken;
        logic [`DS_XLEN-1:0] target;
    } br_bus_t;

endpackage

`default_nettype wire

// File: rtl/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// data path and pc width
`define DS_XLEN 32

// register file geometry
`define DS_REG_AW 5
`define DS_NUM_REGS 32

// one-hot alu operation field
`define DS_ALU_OP_W 13

// mul/div operation code, zero when not a mul/div
`define DS_MD_W 3

// bl writes its return address here
`define DS_LINK_REG 1

`endif
